/* common/spi_bridge_consts.svh */
// Opcodes and frame length are fixed by the SPI host protocol and the FIFO depth must be a power of two of at least 4
`ifndef SPI_BRIDGE_CONSTS_SVH
`define SPI_BRIDGE_CONSTS_SVH

//////////////////////////////////////////////////
// SPI frame
//////////////////////////////////////////////////
`define SB_OP_WRITE    8'h02  // 32-bit write
`define SB_OP_READ     8'h03  // 32-bit read, data field ignored
`define SB_FRAME_BITS  56     // Opcode + address + data

//////////////////////////////////////////////////
// Command FIFO and status byte
//////////////////////////////////////////////////
`define SB_FIFO_DEPTH  8
`define SB_ST_OVF      7      // Sticky, frame lost on full FIFO
`define SB_ST_ERR      6      // Last response not OKAY
`define SB_ST_RESP     1:0    // Last AXI response code

`endif

/* common/spi_bridge_pkg.sv */
// Types shared by the SPI side and the AXI4-Lite side with widths fixed to a 16-bit address and a 32-bit word
package spi_bridge_pkg;

   // Byte address carried in the SPI frame
   typedef logic [15:0] bus_addr_t;

   // One bus data word
   typedef logic [31:0] bus_data_t;

   // AXI response code, 2'b00 is OKAY
   typedef logic [1:0] axi_resp_t;

   // Readback status byte
   typedef logic [7:0] spi_status_t;

   // FIFO word laid out as write flag, address, data
   // bit 48 write flag, 47:32 address, 31:0 data
   typedef logic [48:0] bridge_cmd_t;

   // AXI4-Lite master FSM
   typedef enum logic [2:0] {
      ST_IDLE,   // Waiting for a command
      ST_WRITE,  // AW and W outstanding
      ST_WRESP,  // Waiting for B
      ST_RADDR,  // AR outstanding
      ST_RDATA   // Waiting for R
   } axil_state_t;

endpackage

/* spi_frame/spi_frame_port.sv */
// SPI mode 0 only and the readback of a command appears only after further sclk edges so dummy frames may be needed
`timescale 1ns/100ps
`include "spi_bridge_consts.svh"

module spi_frame_port (
   input  logic                        i_sclk,
   input  logic                        i_arst_n,
   input  logic                        i_ss_n,
   input  logic                        i_mosi,
   output logic                        o_miso,
   output logic                        o_miso_en,
   // Command FIFO write side
   input  logic                        i_full,
   output logic                        o_push,
   output spi_bridge_pkg::bridge_cmd_t o_cmd,
   // Response return path
   input  logic                        i_rsp_toggle,
   input  spi_bridge_pkg::bus_data_t   i_rsp_data,
   input  spi_bridge_pkg::axi_resp_t   i_rsp_code,
   output logic                        o_rsp_ack
);

   localparam int CNT_W   = $clog2(`SB_FRAME_BITS);
   localparam int RB_BITS = 40;  // Data word + status byte
   localparam logic [CNT_W-1:0] LAST_BIT   = CNT_W'(`SB_FRAME_BITS - 1);
   localparam logic [CNT_W-1:0] STATUS_END = CNT_W'(RB_BITS - 1);

   logic [CNT_W-1:0]                bit_cnt;
   logic [`SB_FRAME_BITS-2:0]       shift_in;
   logic [`SB_FRAME_BITS-1:0]       frame;
   logic [7:0]                      opcode;
   logic                            is_write;
   logic                            op_valid;
   logic                            frame_end;
   logic                            ovf_flag;
   logic [1:0]                      rsp_sync;
   spi_bridge_pkg::bus_data_t       rb_data;
   spi_bridge_pkg::axi_resp_t       rb_code;
   spi_bridge_pkg::spi_status_t     status;
   logic [RB_BITS-1:0]              rb_word;
   logic [RB_BITS-1:0]              tx_sr;
   logic                            miso_q;

   assign o_miso_en = ~i_ss_n;

   //////////////////////////////////////////////////
   // Receive side
   //////////////////////////////////////////////////
   // Slave select high aborts the frame at once
   always_ff @(posedge i_sclk or negedge i_arst_n or posedge i_ss_n) begin
      if (!i_arst_n)
         bit_cnt <= '0;
      else if (i_ss_n)
         bit_cnt <= '0;
      else if (bit_cnt == LAST_BIT)
         bit_cnt <= '0;
      else
         bit_cnt <= bit_cnt + 1'b1;
   end

   always_ff @(posedge i_sclk) begin
      shift_in <= {shift_in[`SB_FRAME_BITS-3:0], i_mosi};
   end

   // Last bit is taken straight from mosi
   assign frame     = {shift_in, i_mosi};
   assign opcode    = frame[`SB_FRAME_BITS-1 -: 8];
   assign is_write  = (opcode == `SB_OP_WRITE);
   assign op_valid  = is_write || (opcode == `SB_OP_READ);
   assign frame_end = (bit_cnt == LAST_BIT);

   assign o_push = frame_end && op_valid && !i_full;
   assign o_cmd  = {is_write, frame[47:32], frame[31:0]};

   always_ff @(posedge i_sclk or negedge i_arst_n) begin
      if (!i_arst_n)
         ovf_flag <= 1'b0;
      else if (frame_end && op_valid && i_full)
         ovf_flag <= 1'b1;
      else if (bit_cnt == STATUS_END)  // Status byte fully sent
         ovf_flag <= 1'b0;
   end

   //////////////////////////////////////////////////
   // Response capture
   //////////////////////////////////////////////////
   always_ff @(posedge i_sclk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         rsp_sync <= '0;
         rb_data  <= '0;
         rb_code  <= '0;
      end else begin
         rsp_sync <= {rsp_sync[0], i_rsp_toggle};
         if (rsp_sync[0] != rsp_sync[1]) begin  // Toggle edge
            rb_data <= i_rsp_data;
            rb_code <= i_rsp_code;
         end
      end
   end

   assign o_rsp_ack = rsp_sync[1];

   always_comb begin
      status              = '0;
      status[`SB_ST_OVF]  = ovf_flag;
      status[`SB_ST_ERR]  = (rb_code != 2'b00);
      status[`SB_ST_RESP] = rb_code;
   end

   assign rb_word = {rb_data, status};

   //////////////////////////////////////////////////
   // Transmit side
   //////////////////////////////////////////////////
   // Snapshot on the first edge keeps the word consistent
   always_ff @(posedge i_sclk) begin
      if (bit_cnt == '0)
         tx_sr <= {rb_word[RB_BITS-2:0], 1'b0};
      else
         tx_sr <= {tx_sr[RB_BITS-2:0], 1'b0};
   end

   always_ff @(negedge i_sclk or negedge i_arst_n) begin
      if (!i_arst_n)
         miso_q <= 1'b0;
      else if (bit_cnt == '0)
         miso_q <= rb_word[RB_BITS-1];
      else
         miso_q <= tx_sr[RB_BITS-1];
   end

   // First bit must be out before any sclk edge
   assign o_miso = (bit_cnt == '0) ? rb_word[RB_BITS-1] : miso_q;

endmodule

/* cmd_fifo/cmd_fifo_async.sv */
// Dual-clock show-ahead FIFO where DEPTH must be a power of two of at least 4 and both flags are conservative
`timescale 1ns/100ps

module cmd_fifo_async #(
   parameter int DEPTH = 8
) (
   // Write side
   input  logic                        i_wclk,
   input  logic                        i_arst_n,
   input  logic                        i_push,
   input  spi_bridge_pkg::bridge_cmd_t i_wdata,
   output logic                        o_full,
   // Read side
   input  logic                        i_rclk,
   input  logic                        i_pop,
   output logic                        o_empty,
   output spi_bridge_pkg::bridge_cmd_t o_rdata
);

   localparam int AW = $clog2(DEPTH);
   // Gray full pattern, top two bits inverted
   localparam logic [AW:0] FULL_MASK = {2'b11, {(AW-1){1'b0}}};

   spi_bridge_pkg::bridge_cmd_t mem [0:DEPTH-1];

   logic [AW:0] wbin;
   logic [AW:0] wbin_nxt;
   logic [AW:0] wgray;
   logic [AW:0] rbin;
   logic [AW:0] rbin_nxt;
   logic [AW:0] rgray;
   logic [AW:0] rgray_s1;
   logic [AW:0] rgray_s2;
   logic [AW:0] wgray_s1;
   logic [AW:0] wgray_s2;
   logic        do_wr;
   logic        do_rd;

   //////////////////////////////////////////////////
   // Write clock domain
   //////////////////////////////////////////////////
   assign do_wr    = i_push && !o_full;
   assign wbin_nxt = wbin + 1'b1;

   always_ff @(posedge i_wclk) begin
      if (do_wr)
         mem[wbin[AW-1:0]] <= i_wdata;
   end

   always_ff @(posedge i_wclk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         wbin  <= '0;
         wgray <= '0;
      end else if (do_wr) begin
         wbin  <= wbin_nxt;
         wgray <= wbin_nxt ^ (wbin_nxt >> 1);
      end
   end

   // Read pointer into the write domain
   always_ff @(posedge i_wclk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         rgray_s1 <= '0;
         rgray_s2 <= '0;
      end else begin
         rgray_s1 <= rgray;
         rgray_s2 <= rgray_s1;
      end
   end

   assign o_full = ((wgray ^ rgray_s2) == FULL_MASK);

   //////////////////////////////////////////////////
   // Read clock domain
   //////////////////////////////////////////////////
   assign do_rd    = i_pop && !o_empty;
   assign rbin_nxt = rbin + 1'b1;

   always_ff @(posedge i_rclk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         rbin  <= '0;
         rgray <= '0;
      end else if (do_rd) begin
         rbin  <= rbin_nxt;
         rgray <= rbin_nxt ^ (rbin_nxt >> 1);
      end
   end

   // Write pointer into the read domain
   always_ff @(posedge i_rclk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         wgray_s1 <= '0;
         wgray_s2 <= '0;
      end else begin
         wgray_s1 <= wgray;
         wgray_s2 <= wgray_s1;
      end
   end

   assign o_empty = (rgray == wgray_s2);
   assign o_rdata = mem[rbin[AW-1:0]];  // Head entry, valid while not empty

endmodule

/* logic/axil_cmd_master.sv */
// One AXI4-Lite transaction at a time with full write strobes and the response published by toggle handshake
`timescale 1ns/100ps

module axil_cmd_master (
   input  logic                        i_axi_clk,
   input  logic                        i_arst_n,
   // Command FIFO read side
   input  logic                        i_empty,
   input  spi_bridge_pkg::bridge_cmd_t i_cmd,
   output logic                        o_pop,
   // Response to the sclk domain
   output logic                        o_rsp_toggle,
   output spi_bridge_pkg::bus_data_t   o_rsp_data,
   output spi_bridge_pkg::axi_resp_t   o_rsp_code,
   input  logic                        i_rsp_ack,
   // AXI4-Lite master
   output logic                        o_awvalid,
   input  logic                        i_awready,
   output spi_bridge_pkg::bus_addr_t   o_awaddr,
   output logic                        o_wvalid,
   input  logic                        i_wready,
   output spi_bridge_pkg::bus_data_t   o_wdata,
   output logic [3:0]                  o_wstrb,
   input  logic                        i_bvalid,
   output logic                        o_bready,
   input  spi_bridge_pkg::axi_resp_t   i_bresp,
   output logic                        o_arvalid,
   input  logic                        i_arready,
   output spi_bridge_pkg::bus_addr_t   o_araddr,
   input  logic                        i_rvalid,
   output logic                        o_rready,
   input  spi_bridge_pkg::bus_data_t   i_rdata,
   input  spi_bridge_pkg::axi_resp_t   i_rresp
);

   spi_bridge_pkg::axil_state_t state;
   spi_bridge_pkg::bus_data_t   pend_data;
   spi_bridge_pkg::axi_resp_t   pend_code;
   logic                        pend_valid;
   logic [1:0]                  ack_sync;
   logic                        pub_go;
   logic                        aw_left;
   logic                        w_left;
   logic                        b_done;
   logic                        r_done;

   assign o_pop   = (state == spi_bridge_pkg::ST_IDLE) && !i_empty;
   assign o_wstrb = 4'hF;  // Word writes only
   assign aw_left = o_awvalid && !i_awready;
   assign w_left  = o_wvalid && !i_wready;
   assign b_done  = i_bvalid && o_bready;
   assign r_done  = i_rvalid && o_rready;

   // Payload taken at the pop
   always_ff @(posedge i_axi_clk) begin
      if (o_pop) begin
         o_awaddr <= i_cmd[47:32];
         o_araddr <= i_cmd[47:32];
         o_wdata  <= i_cmd[31:0];
      end
   end

   //////////////////////////////////////////////////
   // Transaction FSM
   //////////////////////////////////////////////////
   always_ff @(posedge i_axi_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         state     <= spi_bridge_pkg::ST_IDLE;
         o_awvalid <= 1'b0;
         o_wvalid  <= 1'b0;
         o_bready  <= 1'b0;
         o_arvalid <= 1'b0;
         o_rready  <= 1'b0;
      end else begin
         case (state)
            spi_bridge_pkg::ST_IDLE: if (o_pop) begin
               if (i_cmd[48]) begin  // Write flag
                  o_awvalid <= 1'b1;
                  o_wvalid  <= 1'b1;
                  state     <= spi_bridge_pkg::ST_WRITE;
               end else begin
                  o_arvalid <= 1'b1;
                  state     <= spi_bridge_pkg::ST_RADDR;
               end
            end
            spi_bridge_pkg::ST_WRITE: begin
               o_awvalid <= aw_left;
               o_wvalid  <= w_left;
               if (!aw_left && !w_left) begin
                  o_bready <= 1'b1;
                  state    <= spi_bridge_pkg::ST_WRESP;
               end
            end
            spi_bridge_pkg::ST_WRESP: if (i_bvalid) begin
               o_bready <= 1'b0;
               state    <= spi_bridge_pkg::ST_IDLE;
            end
            spi_bridge_pkg::ST_RADDR: if (i_arready) begin
               o_arvalid <= 1'b0;
               o_rready  <= 1'b1;
               state     <= spi_bridge_pkg::ST_RDATA;
            end
            spi_bridge_pkg::ST_RDATA: if (i_rvalid) begin
               o_rready <= 1'b0;
               state    <= spi_bridge_pkg::ST_IDLE;
            end
            default: state <= spi_bridge_pkg::ST_IDLE;
         endcase
      end
   end

   //////////////////////////////////////////////////
   // Response publish
   //////////////////////////////////////////////////
   // Wait until sclk side has seen the last flip
   assign pub_go = pend_valid && (ack_sync[1] == o_rsp_toggle);

   always_ff @(posedge i_axi_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         ack_sync     <= '0;
         pend_valid   <= 1'b0;
         pend_data    <= '0;
         pend_code    <= '0;
         o_rsp_toggle <= 1'b0;
         o_rsp_data   <= '0;
         o_rsp_code   <= '0;
      end else begin
         ack_sync <= {ack_sync[0], i_rsp_ack};
         if (pub_go) begin
            o_rsp_data   <= pend_data;
            o_rsp_code   <= pend_code;
            o_rsp_toggle <= ~o_rsp_toggle;
            pend_valid   <= 1'b0;
         end
         if (b_done) begin  // Writes leave the data word alone
            pend_code  <= i_bresp;
            pend_valid <= 1'b1;
         end
         if (r_done) begin
            pend_data  <= i_rdata;
            pend_code  <= i_rresp;
            pend_valid <= 1'b1;
         end
      end
   end

endmodule

/* logic/spi_axil_bridge.sv */
// Release i_arst_n only while sclk is idle since it resets both clock domains directly
`timescale 1ns/100ps
`include "spi_bridge_consts.svh"

module spi_axil_bridge (
   input  logic                      i_sclk,
   input  logic                      i_axi_clk,
   input  logic                      i_arst_n,
   // SPI pins
   input  logic                      i_ss_n,
   input  logic                      i_mosi,
   output logic                      o_miso,
   output logic                      o_miso_en,
   // AXI4-Lite master
   output logic                      o_awvalid,
   input  logic                      i_awready,
   output spi_bridge_pkg::bus_addr_t o_awaddr,
   output logic                      o_wvalid,
   input  logic                      i_wready,
   output spi_bridge_pkg::bus_data_t o_wdata,
   output logic [3:0]                o_wstrb,
   input  logic                      i_bvalid,
   output logic                      o_bready,
   input  spi_bridge_pkg::axi_resp_t i_bresp,
   output logic                      o_arvalid,
   input  logic                      i_arready,
   output spi_bridge_pkg::bus_addr_t o_araddr,
   input  logic                      i_rvalid,
   output logic                      o_rready,
   input  spi_bridge_pkg::bus_data_t i_rdata,
   input  spi_bridge_pkg::axi_resp_t i_rresp
);

   logic                        w_push;
   logic                        w_full;
   spi_bridge_pkg::bridge_cmd_t w_cmd;
   logic                        w_pop;
   logic                        w_empty;
   spi_bridge_pkg::bridge_cmd_t w_rd_cmd;
   logic                        w_rsp_toggle;
   logic                        w_rsp_ack;
   spi_bridge_pkg::bus_data_t   w_rsp_data;
   spi_bridge_pkg::axi_resp_t   w_rsp_code;

   spi_frame_port u_frame (
      .i_sclk(i_sclk), .i_arst_n(i_arst_n), .i_ss_n(i_ss_n), .i_mosi(i_mosi),
      .o_miso(o_miso), .o_miso_en(o_miso_en),
      .i_full(w_full), .o_push(w_push), .o_cmd(w_cmd),
      .i_rsp_toggle(w_rsp_toggle), .i_rsp_data(w_rsp_data),
      .i_rsp_code(w_rsp_code), .o_rsp_ack(w_rsp_ack)
   );

   cmd_fifo_async #(.DEPTH(`SB_FIFO_DEPTH)) u_fifo (
      .i_wclk(i_sclk), .i_arst_n(i_arst_n), .i_push(w_push), .i_wdata(w_cmd),
      .o_full(w_full),
      .i_rclk(i_axi_clk), .i_pop(w_pop), .o_empty(w_empty), .o_rdata(w_rd_cmd)
   );

   axil_cmd_master u_master (
      .i_axi_clk(i_axi_clk), .i_arst_n(i_arst_n),
      .i_empty(w_empty), .i_cmd(w_rd_cmd), .o_pop(w_pop),
      .o_rsp_toggle(w_rsp_toggle), .o_rsp_data(w_rsp_data),
      .o_rsp_code(w_rsp_code), .i_rsp_ack(w_rsp_ack),
      .o_awvalid(o_awvalid), .i_awready(i_awready), .o_awaddr(o_awaddr),
      .o_wvalid(o_wvalid), .i_wready(i_wready), .o_wdata(o_wdata), .o_wstrb(o_wstrb),
      .i_bvalid(i_bvalid), .o_bready(o_bready), .i_bresp(i_bresp),
      .o_arvalid(o_arvalid), .i_arready(i_arready), .o_araddr(o_araddr),
      .i_rvalid(i_rvalid), .o_rready(o_rready), .i_rdata(i_rdata), .i_rresp(i_rresp)
   );

endmodule

/* test/tb_axil_mem.sv */
// AXI4-Lite slave model with 256 words that accepts AW and W together and answers SLVERR at 0x8000 and above
`timescale 1ns/100ps

module tb_axil_mem (
   input  logic                      i_clk,
   input  logic                      i_arst_n,
   input  logic                      i_stall,   // Holds all ready signals low
   input  logic                      i_awvalid,
   output logic                      o_awready,
   input  spi_bridge_pkg::bus_addr_t i_awaddr,
   input  logic                      i_wvalid,
   output logic                      o_wready,
   input  spi_bridge_pkg::bus_data_t i_wdata,
   output logic                      o_bvalid,
   input  logic                      i_bready,
   output spi_bridge_pkg::axi_resp_t o_bresp,
   input  logic                      i_arvalid,
   output logic                      o_arready,
   input  spi_bridge_pkg::bus_addr_t i_araddr,
   output logic                      o_rvalid,
   input  logic                      i_rready,
   output spi_bridge_pkg::bus_data_t o_rdata,
   output spi_bridge_pkg::axi_resp_t o_rresp
);

   spi_bridge_pkg::bus_data_t mem [0:255];

   initial begin
      for (int i = 0; i < 256; i++)
         mem[i] = {8'hC3 ^ i[7:0], i[7:0], ~i[7:0], 8'h5A ^ i[7:0]};  // Whole index in every byte
   end

   assign o_awready = !i_stall && i_awvalid && i_wvalid && !o_bvalid;
   assign o_wready  = o_awready;
   assign o_arready = !i_stall && i_arvalid && !o_rvalid;

   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         o_bvalid <= 1'b0;
         o_bresp  <= 2'b00;
         o_rvalid <= 1'b0;
         o_rdata  <= '0;
         o_rresp  <= 2'b00;
      end else begin
         if (o_awready) begin
            o_bvalid <= 1'b1;
            o_bresp  <= i_awaddr[15] ? 2'b10 : 2'b00;
            if (!i_awaddr[15])
               mem[i_awaddr[9:2]] <= i_wdata;
         end else if (o_bvalid && i_bready)
            o_bvalid <= 1'b0;
         if (o_arready) begin
            o_rvalid <= 1'b1;
            o_rresp  <= i_araddr[15] ? 2'b10 : 2'b00;
            o_rdata  <= i_araddr[15] ? '0 : mem[i_araddr[9:2]];  // No data on error
         end else if (o_rvalid && i_rready)
            o_rvalid <= 1'b0;
      end
   end

endmodule

/* test/spi_bridge_properties.sv */
// Handshake and pin checks sampled on the bus clock and bound to every spi_axil_bridge instance
`timescale 1ns/100ps

module spi_bridge_properties (
   input logic                      i_axi_clk,
   input logic                      i_arst_n,
   input logic                      i_ss_n,
   input logic                      o_miso_en,
   input logic                      o_awvalid,
   input logic                      i_awready,
   input spi_bridge_pkg::bus_addr_t o_awaddr,
   input logic                      o_wvalid,
   input logic                      i_wready,
   input spi_bridge_pkg::bus_data_t o_wdata,
   input logic [3:0]                o_wstrb,
   input logic                      o_arvalid,
   input logic                      i_arready,
   input spi_bridge_pkg::bus_addr_t o_araddr
);

   aw_hold: assert property (@(posedge i_axi_clk) disable iff (!i_arst_n)
      (o_awvalid && !i_awready) |=> (o_awvalid && $stable(o_awaddr)))
      else $error("awvalid or awaddr changed before awready");

   w_hold: assert property (@(posedge i_axi_clk) disable iff (!i_arst_n)
      (o_wvalid && !i_wready) |=> (o_wvalid && $stable(o_wdata)))
      else $error("wvalid or wdata changed before wready");

   ar_hold: assert property (@(posedge i_axi_clk) disable iff (!i_arst_n)
      (o_arvalid && !i_arready) |=> (o_arvalid && $stable(o_araddr)))
      else $error("arvalid or araddr changed before arready");

   strb_full: assert property (@(posedge i_axi_clk) o_wvalid |-> (o_wstrb == 4'hF))
      else $error("wstrb not all ones during wvalid");

   // Holds through reset too
   miso_en: assert property (@(posedge i_axi_clk) o_miso_en == !i_ss_n)
      else $error("o_miso_en does not follow i_ss_n");

endmodule

bind spi_axil_bridge spi_bridge_properties u_props (
   .i_axi_clk(i_axi_clk), .i_arst_n(i_arst_n), .i_ss_n(i_ss_n), .o_miso_en(o_miso_en),
   .o_awvalid(o_awvalid), .i_awready(i_awready), .o_awaddr(o_awaddr),
   .o_wvalid(o_wvalid), .i_wready(i_wready), .o_wdata(o_wdata), .o_wstrb(o_wstrb),
   .o_arvalid(o_arvalid), .i_arready(i_arready), .o_araddr(o_araddr)
);

/* test/tb_spi_axil_bridge.sv */
// Drives sclk at half the bus clock rate and expects readback only after a read has fully completed
`timescale 1ns/100ps
`include "spi_bridge_consts.svh"

module tb_spi_axil_bridge;

   logic clk, arst_n, sclk, ss_n, mosi, stall;
   logic miso, miso_en, awvalid, awready, wvalid, wready, bvalid, bready;
   logic arvalid, arready, rvalid, rready;
   logic [3:0] wstrb;
   spi_bridge_pkg::bus_addr_t awaddr, araddr;
   spi_bridge_pkg::bus_data_t wdata, rdata;
   spi_bridge_pkg::axi_resp_t bresp, rresp;

   spi_bridge_pkg::bus_addr_t exp_addr [$];
   spi_bridge_pkg::bus_data_t exp_data [$];
   spi_bridge_pkg::bus_addr_t exp_raddr [$];
   spi_bridge_pkg::bus_data_t mirror [logic [7:0]];
   spi_bridge_pkg::bus_data_t model_rd;      // Last read word
   spi_bridge_pkg::axi_resp_t model_code;
   logic model_ovf;
   int errors, wr_seen, rd_seen, miso_en_errs, tests_run, tests_bad, seed_val;

   spi_axil_bridge dut0 (
      .i_sclk(sclk), .i_axi_clk(clk), .i_arst_n(arst_n), .i_ss_n(ss_n), .i_mosi(mosi),
      .o_miso(miso), .o_miso_en(miso_en),
      .o_awvalid(awvalid), .i_awready(awready), .o_awaddr(awaddr),
      .o_wvalid(wvalid), .i_wready(wready), .o_wdata(wdata), .o_wstrb(wstrb),
      .i_bvalid(bvalid), .o_bready(bready), .i_bresp(bresp),
      .o_arvalid(arvalid), .i_arready(arready), .o_araddr(araddr),
      .i_rvalid(rvalid), .o_rready(rready), .i_rdata(rdata), .i_rresp(rresp)
   );

   tb_axil_mem u_mem (
      .i_clk(clk), .i_arst_n(arst_n), .i_stall(stall),
      .i_awvalid(awvalid), .o_awready(awready), .i_awaddr(awaddr),
      .i_wvalid(wvalid), .o_wready(wready), .i_wdata(wdata),
      .o_bvalid(bvalid), .i_bready(bready), .o_bresp(bresp),
      .i_arvalid(arvalid), .o_arready(arready), .i_araddr(araddr),
      .o_rvalid(rvalid), .i_rready(rready), .o_rdata(rdata), .o_rresp(rresp)
   );

   always #50 clk = ~clk;

   //////////////////////////////////////////////////
   // Compare tasks
   //////////////////////////////////////////////////
   task automatic check_data(input string name, input spi_bridge_pkg::bus_data_t got,
                             input spi_bridge_pkg::bus_data_t exp);
      if (got !== exp) begin
         $display("MISMATCH %s got 0x%08h expected 0x%08h", name, got, exp);
         errors++;
      end
   endtask

   task automatic check_addr(input string name, input spi_bridge_pkg::bus_addr_t got,
                             input spi_bridge_pkg::bus_addr_t exp);
      if (got !== exp) begin
         $display("MISMATCH %s got 0x%04h expected 0x%04h", name, got, exp);
         errors++;
      end
   endtask

   task automatic check_status(input string name, input spi_bridge_pkg::spi_status_t got,
                               input spi_bridge_pkg::spi_status_t exp);
      if (got !== exp) begin
         $display("MISMATCH %s got 0x%02h expected 0x%02h", name, got, exp);
         errors++;
      end
   endtask

   //////////////////////////////////////////////////
   // Reference model
   //////////////////////////////////////////////////
   // Readback word the next frame should shift out
   function automatic logic [39:0] ref_readback();
      spi_bridge_pkg::spi_status_t st;
      st = '0;
      st[`SB_ST_OVF]  = model_ovf;
      st[`SB_ST_ERR]  = (model_code != 2'b00);
      st[`SB_ST_RESP] = model_code;
      return {model_rd, st};
   endfunction

   function automatic void model_update(input logic [7:0] op, input logic [15:0] addr,
                                        input logic [31:0] data, input int nbits,
                                        input logic dropped);
      if (nbits >= 40)
         model_ovf = 1'b0;  // Cleared once the status byte went out
      if (nbits == `SB_FRAME_BITS && (op == `SB_OP_WRITE || op == `SB_OP_READ)) begin
         if (dropped)
            model_ovf = 1'b1;
         else begin
            model_code = addr[15] ? 2'b10 : 2'b00;
            if (op == `SB_OP_WRITE && !addr[15])
               mirror[addr[9:2]] = data;
            if (op == `SB_OP_READ)
               model_rd = (addr[15] || !mirror.exists(addr[9:2])) ? '0 : mirror[addr[9:2]];
         end
      end
   endfunction

   // AXI write monitor
   always @(posedge clk) begin
      if (arst_n && awvalid && awready && wvalid && wready) begin
         if (exp_addr.size() == 0) begin
            $display("Unexpected AXI write to 0x%04h", awaddr);
            errors++;
         end else begin
            check_addr("o_awaddr", awaddr, exp_addr.pop_front());
            check_data("o_wdata", wdata, exp_data.pop_front());
            if (wstrb !== 4'hF) begin
               $display("MISMATCH o_wstrb got 0x%01h expected 0xf", wstrb);
               errors++;
            end
         end
         wr_seen++;
      end
      if (arst_n && arvalid && arready) begin
         if (exp_raddr.size() == 0) begin
            $display("Unexpected AXI read from 0x%04h", araddr);
            errors++;
         end else
            check_addr("o_araddr", araddr, exp_raddr.pop_front());
      end
      if (arst_n && rvalid && rready)
         rd_seen++;
   end

   always @(negedge clk) begin
      if (miso_en !== ~ss_n)
         miso_en_errs++;
   end

   //////////////////////////////////////////////////
   // SPI driver and waits
   //////////////////////////////////////////////////
   task automatic send_frame(input logic [7:0] op, input logic [15:0] addr,
                             input logic [31:0] data, input int nbits, input logic dropped,
                             output logic [39:0] rb);
      logic [55:0] frm;
      logic [55:0] got;
      frm = {op, addr, data};
      got = '0;
      // Bus traffic this frame should cause
      if (!dropped && nbits == `SB_FRAME_BITS) begin
         if (op == `SB_OP_WRITE) begin
            exp_addr.push_back(addr);
            exp_data.push_back(data);
         end else if (op == `SB_OP_READ)
            exp_raddr.push_back(addr);
      end
      @(posedge clk);
      ss_n <= 1'b0;
      mosi <= frm[55];
      for (int i = 0; i < nbits; i++) begin
         @(posedge clk);
         got[55-i] = miso;  // Stable since the last falling edge
         sclk <= 1'b1;
         @(posedge clk);
         sclk <= 1'b0;
         if (i + 1 < nbits)
            mosi <= frm[54-i];
      end
      @(posedge clk);
      ss_n <= 1'b1;
      repeat (2) @(posedge clk);
      rb = got[55:16];
      model_update(op, addr, data, nbits, dropped);
   endtask

   task automatic wait_axi(input int wr_target, input int rd_target);
      int n;
      n = 0;
      while ((wr_seen < wr_target || rd_seen < rd_target) && n < 3000) begin
         @(posedge clk);
         n++;
      end
      if (n >= 3000) begin
         $display("Timeout waiting for AXI transactions to finish");
         errors++;
      end
   endtask

   // The response settles during the first dummy frame and the second one is checked in full
   task automatic check_readback(input string tag);
      logic [39:0] rb;
      logic [39:0] exp;
      spi_bridge_pkg::spi_status_t ovf_mask;
      ovf_mask = '0;
      ovf_mask[`SB_ST_OVF] = 1'b1;
      exp = ref_readback();  // Overflow flag lives in the sclk domain
      send_frame(8'h00, 16'h0, 32'h0, `SB_FRAME_BITS, 1'b0, rb);
      check_status({tag, " first overflow bit"}, rb[7:0] & ovf_mask, exp[7:0] & ovf_mask);
      exp = ref_readback();
      send_frame(8'h00, 16'h0, 32'h0, `SB_FRAME_BITS, 1'b0, rb);
      check_data({tag, " readback data"}, rb[39:8], exp[39:8]);
      check_status({tag, " status"}, rb[7:0], exp[7:0]);
   endtask

   task automatic end_test(input string name, input int err_before);
      tests_run++;
      if (errors == err_before)
         $display("test %s: ok", name);
      else begin
         tests_bad++;
         $display("test %s: errors %0d", name, errors - err_before);
      end
   endtask

   //////////////////////////////////////////////////
   // Test sequence
   //////////////////////////////////////////////////
   initial begin
      logic [39:0] rb;
      logic [15:0] a;
      logic [15:0] last_a;
      int e, base;
      clk = 0; arst_n = 0; sclk = 0; ss_n = 1; mosi = 0; stall = 0;
      errors = 0; wr_seen = 0; rd_seen = 0; miso_en_errs = 0;
      tests_run = 0; tests_bad = 0;
      model_rd = '0; model_code = '0; model_ovf = 1'b0;
      seed_val = $urandom(32'h028a_b469);
      repeat (2) @(posedge clk);
      arst_n <= 1'b1;
      repeat (4) @(posedge clk);

      e = errors;  // Ordered writes
      last_a = '0;
      for (int k = 0; k < 4; k++) begin
         last_a = 16'($urandom()) & 16'h7FFC;
         send_frame(`SB_OP_WRITE, last_a, $urandom(), `SB_FRAME_BITS, 1'b0, rb);
      end
      wait_axi(4, 0);
      end_test("writes", e);

      e = errors;  // Read back the last word
      send_frame(`SB_OP_READ, last_a, 32'hFFFF_FFFF, `SB_FRAME_BITS, 1'b0, rb);
      wait_axi(wr_seen, 1);
      check_readback("read");
      end_test("read", e);

      e = errors;  // Back-pressure and overflow
      base = wr_seen;
      @(posedge clk);
      stall <= 1'b1;
      for (int k = 0; k < `SB_FIFO_DEPTH + 2; k++) begin
         a = 16'($urandom()) & 16'h7FFC;
         send_frame(`SB_OP_WRITE, a, $urandom(), `SB_FRAME_BITS,
                    k == `SB_FIFO_DEPTH + 1, rb);
      end
      if (wr_seen != base) begin
         $display("AXI write completed while the slave was stalled");
         errors++;
      end
      @(posedge clk);
      stall <= 1'b0;
      wait_axi(base + `SB_FIFO_DEPTH + 1, rd_seen);
      check_readback("overflow set");
      check_readback("overflow clear");
      if (exp_addr.size() != 0 || wr_seen != base + `SB_FIFO_DEPTH + 1) begin
         $display("Wrong number of writes after stall release");
         errors++;
      end
      end_test("overflow", e);

      e = errors;  // Error response
      a = (16'($urandom()) & 16'h7FFC) | 16'h8000;
      send_frame(`SB_OP_READ, a, 32'h0, `SB_FRAME_BITS, 1'b0, rb);
      wait_axi(wr_seen, rd_seen + 1);
      check_readback("slverr");
      end_test("slverr", e);

      e = errors;  // Bad opcode and aborted frame
      base = wr_seen + rd_seen;
      send_frame(8'h5A, 16'h0100, 32'h1234_5678, `SB_FRAME_BITS, 1'b0, rb);
      send_frame(`SB_OP_WRITE, 16'h0200, 32'h0BAD_0BAD, 30, 1'b0, rb);
      repeat (40) @(posedge clk);
      if (wr_seen + rd_seen != base) begin
         $display("Dropped frame caused an AXI transaction");
         errors++;
      end
      send_frame(`SB_OP_WRITE, 16'h0044, $urandom(), `SB_FRAME_BITS, 1'b0, rb);
      wait_axi(wr_seen + 1, rd_seen);
      if (exp_addr.size() != 0) begin
         $display("Write after dropped frames did not complete");
         errors++;
      end
      end_test("dropped frames", e);

      e = errors;  // Pin enable seen from time zero
      if (miso_en_errs != 0) begin
         $display("o_miso_en differed from inverted i_ss_n %0d times", miso_en_errs);
         errors++;
      end
      end_test("miso enable", e);

      $display("tests %0d failing %0d errors %0d", tests_run, tests_bad, errors);
      if (errors == 0)
         $display("*** PASSED ***");
      else
         $display("*** FAILED ***");
      $finish;
   end

endmodule

/* filelist.f */
+incdir+common
common/spi_bridge_pkg.sv
spi_frame/spi_frame_port.sv
cmd_fifo/cmd_fifo_async.sv
logic/axil_cmd_master.sv
logic/spi_axil_bridge.sv
test/tb_axil_mem.sv
test/spi_bridge_properties.sv
test/tb_spi_axil_bridge.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
   --top-module tb_spi_axil_bridge \
   -f filelist.f -Mdir obj_dir -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q '\*\*\* FAILED \*\*\*' sim.log; then
   echo "simulation reported failure"
   exit 1
fi
if ! grep -q '\*\*\* PASSED \*\*\*' sim.log; then
   echo "simulation ended without a result"
   exit 1
fi
